// ==== compile.f ====
rtl/ecc_pkg.sv
rtl/ccm_pkg.sv
rtl/ecc_encode.sv
rtl/ecc_decode.sv
rtl/ccm_range_check.sv
rtl/ccm_array.sv
rtl/ccm_read_stage.sv
rtl/ccm_top.sv
test/tb_clock.sv
test/tb_ccm_top.sv

// ==== rtl/ccm_array.sv ====
////////////////////////////////////////////////////////////////////////////
// codeword storage: encoded writes with error injection and a registered
// read port that reports a fault for addresses outside the window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccm_array #(
   parameter int CCM_SIZE = 4                       // KB
) (
   input  logic                  clk,
   input  logic                  rst_l,
   input  ccm_pkg::ccm_wr_t      wr,
   input  logic                  wr_in_range,
   input  ccm_pkg::ccm_rd_req_t  rd_req,
   input  logic                  rd_in_range,
   output ccm_pkg::ccm_rd_word_t rd_word
);

   localparam int DEPTH   = CCM_SIZE * 256;         // 4-byte words
   localparam int INDEX_W = $clog2(DEPTH);

   ecc_pkg::code_word_t mem [DEPTH];

   ecc_pkg::ecc_t       wr_ecc;
   ecc_pkg::code_word_t wr_word;
   logic [INDEX_W-1:0]  wr_idx;
   logic [INDEX_W-1:0]  rd_idx;

   ecc_encode i_ecc_encode (
      .data (wr.data),
      .ecc  (wr_ecc)
   );

   // injection mask applied after encoding
   assign wr_word = {wr_ecc, wr.data} ^ wr.flip;

   // byte lanes ignored
   assign wr_idx = wr.addr[INDEX_W+1:2];
   assign rd_idx = rd_req.addr[INDEX_W+1:2];

   // all zero is the codeword of zero data
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr.wr_en && wr_in_range) begin
         mem[wr_idx] <= wr_word;
      end
   end

   // same-cycle read of a written word sees the old contents
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_word <= '0;
      end else begin
         rd_word.valid <= rd_req.rd_en;
         rd_word.fault <= rd_req.rd_en & ~rd_in_range;
         if (rd_req.rd_en) begin
            rd_word.word <= rd_in_range ? mem[rd_idx] : '0;
         end
      end
   end

endmodule

// ==== rtl/ccm_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// scratchpad memory types: byte address, write and read requests, the
// array read result and the read response
////////////////////////////////////////////////////////////////////////////

package ccm_pkg;

   typedef logic [31:0] addr_t;

   // write request, flip is xored onto the encoded codeword
   typedef struct packed {
      logic                      wr_en;
      addr_t                     addr;
      ecc_pkg::data_t            data;
      logic [ecc_pkg::CODE_W-1:0] flip;
   } ccm_wr_t;

   typedef struct packed {
      logic  rd_en;
      addr_t addr;
   } ccm_rd_req_t;

   // codeword as read out of the array, one cycle after the request
   typedef struct packed {
      logic                valid;
      logic                fault;        // address was outside the window
      ecc_pkg::code_word_t word;
   } ccm_rd_word_t;

   // response to a read, two cycles after the request
   typedef struct packed {
      logic           valid;
      logic           fault;
      logic           single_err;   // corrected
      logic           double_err;   // data not usable
      ecc_pkg::data_t data;
   } ccm_rsp_t;

endpackage

// ==== rtl/ccm_range_check.sv ====
////////////////////////////////////////////////////////////////////////////
// window test of a byte address against the memory start address and size
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccm_range_check #(
   parameter logic [31:0] CCM_SADR = 32'hf004_0000,
   parameter int          CCM_SIZE = 4              // KB
) (
   input  ccm_pkg::addr_t addr,
   output logic           in_range
);

   // bits below the size boundary are the offset inside the window
   // 48 KB rounds up to a 64 KB aligned block
   localparam int MASK_BITS = 10 + $clog2(CCM_SIZE);

   localparam ccm_pkg::addr_t START = CCM_SADR;

   logic block_hit;

   assign block_hit = (addr[31:MASK_BITS] == START[31:MASK_BITS]);

   if (CCM_SIZE == 48) begin : g_size_48
      // top 16 KB of the 64 KB block has no storage behind it
      assign in_range = block_hit & ~(&addr[MASK_BITS-1:MASK_BITS-2]);
   end else begin : g_size_pow2
      assign in_range = block_hit;
   end

endmodule

// ==== rtl/ccm_read_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// ECC decode of the read codeword and the registered read response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccm_read_stage (
   input  logic                  clk,
   input  logic                  rst_l,
   input  ccm_pkg::ccm_rd_word_t rd_word,
   output ccm_pkg::ccm_rsp_t     rsp
);

   logic           dec_en;
   ecc_pkg::data_t dec_data;
   logic           dec_single;
   logic           dec_double;

   // faulted words carry no codeword, keep their flags quiet
   assign dec_en = rd_word.valid & ~rd_word.fault;

   ecc_decode i_ecc_decode (
      .en         (dec_en),
      .word       (rd_word.word),
      .data       (dec_data),
      .single_err (dec_single),
      .double_err (dec_double)
   );

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp <= '0;
      end else begin
         rsp.valid      <= rd_word.valid;   // one cycle per read
         rsp.fault      <= rd_word.fault;
         rsp.single_err <= dec_single;
         rsp.double_err <= dec_double;
         if (rd_word.valid) begin
            rsp.data <= rd_word.fault ? '0 : dec_data;
         end
      end
   end

endmodule

// ==== rtl/ccm_top.sv ====
////////////////////////////////////////////////////////////////////////////
// scratchpad memory top level: address window checks, ECC storage array
// and read response stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccm_top #(
   parameter logic [31:0] CCM_SADR = 32'hf004_0000,
   parameter int          CCM_SIZE = 4              // KB
) (
   input  logic                 clk,
   input  logic                 rst_l,
   input  ccm_pkg::ccm_wr_t     wr,
   input  ccm_pkg::ccm_rd_req_t rd_req,
   output ccm_pkg::ccm_rsp_t    rsp
);

   logic                  wr_in_range;
   logic                  rd_in_range;
   ccm_pkg::ccm_rd_word_t rd_word;

   ccm_range_check #(
      .CCM_SADR (CCM_SADR),
      .CCM_SIZE (CCM_SIZE)
   ) i_wr_range (
      .addr     (wr.addr),
      .in_range (wr_in_range)
   );

   ccm_range_check #(
      .CCM_SADR (CCM_SADR),
      .CCM_SIZE (CCM_SIZE)
   ) i_rd_range (
      .addr     (rd_req.addr),
      .in_range (rd_in_range)
   );

   // first cycle of a read, codeword out of storage
   ccm_array #(
      .CCM_SIZE (CCM_SIZE)
   ) i_ccm_array (
      .clk         (clk),
      .rst_l       (rst_l),
      .wr          (wr),
      .wr_in_range (wr_in_range),
      .rd_req      (rd_req),
      .rd_in_range (rd_in_range),
      .rd_word     (rd_word)
   );

   // second cycle, corrected data and flags
   ccm_read_stage i_ccm_read_stage (
      .clk     (clk),
      .rst_l   (rst_l),
      .rd_word (rd_word),
      .rsp     (rsp)
   );

endmodule

// ==== rtl/ecc_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// syndrome check of one codeword, single-bit correction of the data and
// single / double error classification
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_decode (
   input  logic                en,
   input  ecc_pkg::code_word_t word,
   output ecc_pkg::data_t      data,
   output logic                single_err,
   output logic                double_err
);

   logic [5:0]     syndrome;
   logic           par_odd;
   ecc_pkg::data_t fix_mask;

   // recomputed check bits xor the stored ones
   always_comb begin
      for (int k = 0; k < 6; k++) begin
         syndrome[k] = word.ecc[k] ^ (^(word.data & ecc_pkg::CHK_MASK[k]));
      end
   end

   // a clean codeword has even parity over all 39 bits
   assign par_odd = ^word;

   // the syndrome of a single error is the position of the bad bit
   // position of data bit i is the column i of the coverage table
   always_comb begin
      logic [5:0] col;
      for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
         for (int k = 0; k < 6; k++) begin
            col[k] = ecc_pkg::CHK_MASK[k][i];
         end
         fix_mask[i] = (syndrome == col);
      end
   end

   // odd parity means one bit flipped
   // zero syndrome with odd parity is the parity bit itself
   assign single_err = en & par_odd;
   assign double_err = en & ~par_odd & (|syndrome);

   // check-bit positions never match a data column, so a
   // check-bit error leaves the data as stored
   assign data = single_err ? (word.data ^ fix_mask) : word.data;

endmodule

// ==== rtl/ecc_encode.sv ====
////////////////////////////////////////////////////////////////////////////
// check-bit generation for one 32-bit data word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ecc_encode (
   input  ecc_pkg::data_t data,
   output ecc_pkg::ecc_t  ecc
);

   logic [5:0] hamming;
   logic       parity;

   // each Hamming bit is the xor of the data bits it covers
   always_comb begin
      for (int k = 0; k < 6; k++) begin
         hamming[k] = ^(data & ecc_pkg::CHK_MASK[k]);
      end
   end

   // overall parity over data and Hamming bits,
   // makes the full 39-bit codeword even
   assign parity = (^data) ^ (^hamming);

   assign ecc = {parity, hamming};

endmodule

// ==== rtl/ecc_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// SECDED code definitions for 32-bit words: widths, word types and the
// data-bit coverage of the six Hamming check bits
////////////////////////////////////////////////////////////////////////////

package ecc_pkg;

   parameter int DATA_W = 32;
   parameter int ECC_W  = 7;                  // top bit is the overall parity
   parameter int CODE_W = DATA_W + ECC_W;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ECC_W-1:0]  ecc_t;

   // stored form of one word
   typedef struct packed {
      ecc_t  ecc;
      data_t data;
   } code_word_t;

   // data bits covered by each Hamming check bit
   // data bit i sits at codeword position p (check bits at 1,2,4,8,16,32)
   // and check bit k covers it when bit k of p is set, so the column of
   // this table at bit i is the position itself
   parameter logic [5:0][DATA_W-1:0] CHK_MASK = {
      32'hfc00_0000,                          // check bit 5
      32'h03ff_f800,                          // check bit 4
      32'h03fc_07f0,                          // check bit 3
      32'he3c3_c78e,                          // check bit 2
      32'h9b33_366d,                          // check bit 1
      32'h56aa_ad5b                           // check bit 0
   };

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scratchpad memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_ccm_top -f compile.f -o sim_tb_ccm_top

./obj_dir/sim_tb_ccm_top 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== test/tb_ccm_top.sv ====
////////////////////////////////////////////////////////////////////////////
// table-driven testbench of the scratchpad memory covering reset contents,
// clean writes, single and double error injection and out-of-window accesses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ccm_top;

   localparam int          PERIOD_NS = 20;
   localparam int unsigned SEED      = 32'h2571d4d5;
   localparam int          CODE_W    = ecc_pkg::CODE_W;

   // memory window of the DUT defaults
   localparam ccm_pkg::addr_t CCM_SADR  = 32'hf004_0000;
   localparam ccm_pkg::addr_t CCM_BYTES = 32'h0000_1000;   // 4 KB
   localparam int             WORDS     = 1024;
   localparam int             INDEX_W   = 10;

   // one table row whose read is checked two edges later
   typedef struct packed {
      logic                   wr_en;
      logic                   rd_en;
      logic                   check_data;
      ccm_pkg::addr_t         addr;
      ecc_pkg::data_t         data;
      logic [CODE_W-1:0]      flip;
      ccm_pkg::ccm_rsp_t      want;
   } entry_t;

   logic                 clk;
   logic                 rst_l;
   ccm_pkg::ccm_wr_t     wr;
   ccm_pkg::ccm_rd_req_t rd_req;
   ccm_pkg::ccm_rsp_t    rsp;

   entry_t         tbl[$];
   ecc_pkg::data_t model_data [WORDS];
   int             model_class [WORDS];          // flipped bits per word
   logic           table_built = 1'b0;
   int             cur_entry;

   tb_clock #(
      .PERIOD_NS    (PERIOD_NS),
      .RESET_CYCLES (5)
   ) i_tb_clock (
      .clk   (clk),
      .rst_l (rst_l)
   );

   ccm_top i_ccm_top (
      .clk    (clk),
      .rst_l  (rst_l),
      .wr     (wr),
      .rd_req (rd_req),
      .rsp    (rsp)
   );

   function automatic ccm_pkg::addr_t word_addr(input int idx);
      return CCM_SADR + ccm_pkg::addr_t'(idx * 4);
   endfunction

   function automatic logic in_window(input ccm_pkg::addr_t addr);
      return (addr >= CCM_SADR) && (addr < CCM_SADR + CCM_BYTES);
   endfunction

   // response the model predicts for a read of addr right now
   function automatic ccm_pkg::ccm_rsp_t expected_read(input ccm_pkg::addr_t addr);
      ccm_pkg::ccm_rsp_t r;
      int                idx;
      r       = '0;
      r.valid = 1'b1;
      if (!in_window(addr)) begin
         r.fault = 1'b1;
      end else begin
         idx          = int'(addr[INDEX_W+1:2]);
         r.single_err = (model_class[idx] == 1);
         r.double_err = (model_class[idx] == 2);
         r.data       = model_data[idx];
      end
      return r;
   endfunction

   task automatic update_model(input ccm_pkg::addr_t addr, input ecc_pkg::data_t data,
                               input logic [CODE_W-1:0] flip);
      int idx;
      if (in_window(addr)) begin                 // out-of-window writes are dropped
         idx              = int'(addr[INDEX_W+1:2]);
         model_data[idx]  = data;
         model_class[idx] = $countones(flip);
      end
   endtask

   task automatic read_entry(input ccm_pkg::addr_t addr);
      entry_t e;
      e            = '0;
      e.rd_en      = 1'b1;
      e.addr       = addr;
      e.want       = expected_read(addr);
      e.check_data = !e.want.double_err;         // data of a double error is unusable
      tbl.push_back(e);
   endtask

   task automatic write_entry(input ccm_pkg::addr_t addr, input ecc_pkg::data_t data,
                              input logic [CODE_W-1:0] flip);
      entry_t e;
      e       = '0;
      e.wr_en = 1'b1;
      e.addr  = addr;
      e.data  = data;
      e.flip  = flip;
      update_model(addr, data, flip);
      tbl.push_back(e);
   endtask

   // read and write of one word in the same cycle return the old data
   task automatic write_read_entry(input ccm_pkg::addr_t addr, input ecc_pkg::data_t data);
      entry_t e;
      e            = '0;
      e.wr_en      = 1'b1;
      e.rd_en      = 1'b1;
      e.addr       = addr;
      e.data       = data;
      e.want       = expected_read(addr);
      e.check_data = 1'b1;
      update_model(addr, data, '0);
      tbl.push_back(e);
   endtask

   task automatic idle_entry();
      entry_t e;
      e = '0;
      tbl.push_back(e);
   endtask

   task automatic build_table();
      logic [CODE_W-1:0] flip;
      for (int i = 0; i < WORDS; i++) begin
         model_data[i]  = '0;
         model_class[i] = 0;
      end
      // reset contents read back to back
      read_entry(word_addr(0));
      read_entry(word_addr(5));
      read_entry(word_addr(WORDS - 1));
      read_entry(word_addr(5));
      idle_entry();
      for (int w = 16; w < 24; w++) begin
         write_entry(word_addr(w), $urandom(), '0);
      end
      for (int w = 16; w < 24; w++) begin
         read_entry(word_addr(w));
      end
      write_read_entry(word_addr(16), $urandom());
      read_entry(word_addr(16));
      // one flipped bit over data, check and parity positions
      for (int b = 0; b < CODE_W; b++) begin
         flip    = '0;
         flip[b] = 1'b1;
         write_entry(word_addr(64 + b), $urandom(), flip);
         read_entry(word_addr(64 + b));
      end
      for (int p = 0; p < 6; p++) begin
         flip             = '0;
         flip[p]          = 1'b1;
         flip[38 - 5 * p] = 1'b1;
         write_entry(word_addr(200 + p), $urandom(), flip);
         read_entry(word_addr(200 + p));
      end
      // outside the window
      read_entry(CCM_SADR + CCM_BYTES);
      read_entry(CCM_SADR - 32'd4);
      read_entry(32'h0000_0040);
      read_entry(32'hf005_0000);
      write_entry(CCM_SADR + CCM_BYTES + 32'd64, $urandom(), '0);   // index of word 16
      write_entry(32'h0004_0050, $urandom(), '0);                   // index of word 20
      read_entry(word_addr(16));
      read_entry(word_addr(20));
      idle_entry();
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] want,
                                  input logic [31:0] got);
      $display("CHECK FAILED at %0t ns: entry %0d %s expected %h actual %h",
               $time, cur_entry, name, want, got);
      $display("Finished with errors");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic check_data(input string name, input ecc_pkg::data_t want,
                             input ecc_pkg::data_t got);
      if (got !== want) begin
         report_mismatch(name, want, got);
      end
   endtask

   task automatic compare_flags(input ccm_pkg::ccm_rsp_t want, input ccm_pkg::ccm_rsp_t got);
      if (got.valid !== want.valid) begin
         report_mismatch("rsp.valid", 32'(want.valid), 32'(got.valid));
      end
      if (got.fault !== want.fault) begin
         report_mismatch("rsp.fault", 32'(want.fault), 32'(got.fault));
      end
      if (got.single_err !== want.single_err) begin
         report_mismatch("rsp.single_err", 32'(want.single_err), 32'(got.single_err));
      end
      if (got.double_err !== want.double_err) begin
         report_mismatch("rsp.double_err", 32'(want.double_err), 32'(got.double_err));
      end
   endtask

   task automatic drive_entry(input entry_t e);
      wr.wr_en     = e.wr_en;
      wr.addr      = e.addr;
      wr.data      = e.data;
      wr.flip      = e.flip;
      rd_req.rd_en = e.rd_en;
      rd_req.addr  = e.addr;
   endtask

   task automatic verify_entry(input int k);
      cur_entry = k;
      compare_flags(tbl[k].want, rsp);
      if (tbl[k].check_data) begin
         check_data("rsp.data", tbl[k].want.data, rsp.data);
      end
   endtask

   initial begin
      entry_t idle;
      wr     = '0;
      rd_req = '0;
      idle   = '0;
      void'($urandom(SEED));
      build_table();
      table_built = 1'b1;
      wait (rst_l === 1'b1);
      // response of row i-2 is stable at this falling edge
      for (int i = 0; i < tbl.size() + 2; i++) begin
         @(negedge clk);
         if (i >= 2) begin
            verify_entry(i - 2);
         end
         if (i < tbl.size()) begin
            drive_entry(tbl[i]);
         end else begin
            drive_entry(idle);
         end
      end
      $display("Finished with no errors");
      $finish;
   end

   // watchdog limit covers the table rows plus reset and drain
   initial begin
      int limit_ns;
      wait (table_built);
      limit_ns = (tbl.size() + 20) * PERIOD_NS;
      #(limit_ns);
      $display("watchdog: the run did not finish within %0d ns", limit_ns);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== test/tb_clock.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench clock and active-low reset generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst_l
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_l = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);                     // release away from the sampling edge
      rst_l = 1'b1;
   end

endmodule
